//--- Makefile
# Verilator build and run of the access guard testbench

.PHONY: help test clean

help:
	@echo "make test   build and run the simulation, fail unless the log shows a pass"
	@echo "make clean  remove build output and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f pmp_guard.f \
		--top-module tb_pmp_guard -Mdir obj_dir
	./obj_dir/Vtb_pmp_guard | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- pmp_guard.f
+incdir+source
source/pmp_guard_pkg.sv
source/pmp_region_check.sv
source/pmp_csr_bank.sv
source/pmp_access_gate.sv
source/pmp_guard_top.sv
tb/pmp_guard_checker.sv
tb/tb_pmp_guard.sv

//--- source/pmp_access_gate.sv
// Host access gate
`timescale 1ns/1ps
`include "pmp_guard_consts.svh"

module pmp_access_gate import pmp_guard_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  // host request
  input  logic                        h_a_valid_i,
  output logic                        h_a_ready_o,
  input  bus_op_e                     h_a_opcode_i,
  input  logic [31:0]                 h_a_address_i,
  input  logic [31:0]                 h_a_data_i,
  // host response
  output logic                        h_d_valid_o,
  input  logic                        h_d_ready_i,
  output rsp_op_e                     h_d_opcode_o,
  output logic [31:0]                 h_d_data_o,
  output logic                        h_d_error_o,
  // device request
  output logic                        dev_a_valid_o,
  input  logic                        dev_a_ready_i,
  output bus_op_e                     dev_a_opcode_o,
  output logic [31:0]                 dev_a_address_o,
  output logic [31:0]                 dev_a_data_o,
  // device response
  input  logic                        dev_d_valid_i,
  output logic                        dev_d_ready_o,
  input  rsp_op_e                     dev_d_opcode_i,
  input  logic [31:0]                 dev_d_data_i,
  input  logic                        dev_d_error_i,
  // region checker results
  input  logic [`PMP_NUM_REGIONS-1:0] match_i,
  input  logic [`PMP_NUM_REGIONS-1:0] allow_i,
  // bank side
  input  logic                        release_i,
  output logic                        deny_o,
  output logic [31:0]                 deny_addr_o,
  output bus_op_e                     deny_op_o,
  output logic                        irq_o
);

  guard_state_e state_q;
  guard_state_e state_d;
  logic         err_pending_q;
  logic         err_pending_d;
  logic         release_pend_q;
  logic         release_pend_d;
  rsp_op_e      err_op_q;
  logic         any_match;
  logic         granted;
  logic         req_ok;
  logic         in_pass;

  // walk down so the lowest matching region has the last word
  always_comb begin
    any_match = 1'b0;
    granted   = 1'b0;
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_i[i]) begin
        any_match = 1'b1;
        granted   = allow_i[i];
      end
    end
  end

  // no match means deny
  assign req_ok  = any_match && granted;
  assign in_pass = (state_q == st_pass);

  // request path is combinational in pass
  assign dev_a_valid_o   = in_pass && h_a_valid_i && req_ok;
  assign dev_a_opcode_o  = h_a_opcode_i;
  assign dev_a_address_o = h_a_address_i;
  assign dev_a_data_o    = h_a_data_i;
  // a denied request is swallowed at once
  assign h_a_ready_o     = in_pass && (req_ok ? dev_a_ready_i : 1'b1);

  assign deny_o      = in_pass && h_a_valid_i && !req_ok;
  assign deny_addr_o = h_a_address_i;
  assign deny_op_o   = h_a_opcode_i;

  // response mux, the error response overrides the device
  assign h_d_valid_o   = err_pending_q || (in_pass && dev_d_valid_i);
  assign h_d_opcode_o  = err_pending_q ? err_op_q : dev_d_opcode_i;
  assign h_d_data_o    = err_pending_q ? '0 : dev_d_data_i;
  assign h_d_error_o   = err_pending_q || dev_d_error_i;
  assign dev_d_ready_o = in_pass && h_d_ready_i;

  assign irq_o = (state_q == st_block);

  always_comb begin
    state_d        = state_q;
    err_pending_d  = err_pending_q;
    release_pend_d = release_pend_q;
    case (state_q)
      st_pass: begin
        if (deny_o) begin
          state_d       = st_block;
          err_pending_d = 1'b1;
        end
      end
      default: begin
        if (err_pending_q && h_d_ready_i) begin
          err_pending_d = 1'b0;
        end
        // release seen while the error is still out waits here
        if (release_i && err_pending_q) begin
          release_pend_d = 1'b1;
        end
        if ((release_i || release_pend_q) && !err_pending_q) begin
          state_d        = st_pass;
          release_pend_d = 1'b0;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q        <= st_pass;
      err_pending_q  <= 1'b0;
      release_pend_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      err_pending_q  <= err_pending_d;
      release_pend_q <= release_pend_d;
    end
  end

  // opcode of the error response follows the denied request
  always_ff @(posedge clk) begin
    if (deny_o) begin
      err_op_q <= (h_a_opcode_i == op_get) ? access_ack_data : access_ack;
    end
  end

  a_block_no_ready: assert property (
    @(posedge clk) disable iff (!rst)
    (state_q == st_block) |-> !h_a_ready_o
  );

  a_block_no_fwd: assert property (
    @(posedge clk) disable iff (!rst)
    (state_q == st_block) |-> !dev_a_valid_o
  );

endmodule

//--- source/pmp_csr_bank.sv
// Guard register bank
`timescale 1ns/1ps
`include "pmp_guard_consts.svh"

module pmp_csr_bank import pmp_guard_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // cpu request
  input  logic                     cpu_a_valid_i,
  output logic                     cpu_a_ready_o,
  input  bus_op_e                  cpu_a_opcode_i,
  input  logic [31:0]              cpu_a_address_i,
  input  logic [31:0]              cpu_a_data_i,
  // cpu response
  output logic                     cpu_d_valid_o,
  input  logic                     cpu_d_ready_i,
  output rsp_op_e                  cpu_d_opcode_o,
  output logic [31:0]              cpu_d_data_o,
  output logic                     cpu_d_error_o,
  // denial capture from the gate
  input  logic                     deny_i,
  input  logic [31:0]              deny_addr_i,
  input  bus_op_e                  deny_op_i,
  // region setup towards the checkers
  output logic [`PMP_CFG_BITS-1:0] region_cfg_o  [`PMP_NUM_REGIONS],
  output logic [31:0]              region_addr_o [`PMP_NUM_REGIONS],
  output logic [31:0]              region_base_o [`PMP_NUM_REGIONS],
  output logic                     release_o
);

  logic [31:0] cfg_q;
  logic [31:0] addr_q [`PMP_NUM_REGIONS];
  logic [31:0] denied_addr_q;
  bus_op_e     denied_op_q;
  logic        release_q;

  logic        accept;
  logic [2:0]  word_idx;
  logic [1:0]  addr_sel;
  logic        addr_ok;
  logic        is_put;
  logic        is_get;
  logic        is_addr_reg;
  logic        is_read_only;
  logic        req_err;
  logic        wr_en;
  logic [31:0] rd_data;

  // one response in flight at a time
  assign cpu_a_ready_o = !cpu_d_valid_o;
  assign accept        = cpu_a_valid_i && cpu_a_ready_o;

  // word index from bits 4:2, any other address bit is an error
  assign word_idx = cpu_a_address_i[4:2];
  assign addr_ok  = (cpu_a_address_i[31:5] == '0) && (cpu_a_address_i[1:0] == 2'b00);
  assign addr_sel = 2'(word_idx - `PMP_CSR_ADDR0);

  assign is_put       = (cpu_a_opcode_i == op_put_full);
  assign is_get       = (cpu_a_opcode_i == op_get);
  assign is_addr_reg  = (word_idx >= `PMP_CSR_ADDR0) && (word_idx < `PMP_CSR_DENIED_ADDR);
  // denial record is status only
  assign is_read_only = (word_idx == `PMP_CSR_DENIED_ADDR) ||
                        (word_idx == `PMP_CSR_DENIED_OP);

  assign req_err = !addr_ok || !(is_put || is_get) || (is_put && is_read_only);
  assign wr_en   = accept && is_put && !req_err;

  // read mux, release reads back as zero
  always_comb begin
    case (word_idx)
      `PMP_CSR_CFG:         rd_data = cfg_q;
      `PMP_CSR_DENIED_ADDR: rd_data = denied_addr_q;
      `PMP_CSR_DENIED_OP:   rd_data = {29'd0, denied_op_q};
      `PMP_CSR_RELEASE:     rd_data = '0;
      default:              rd_data = addr_q[addr_sel];
    endcase
  end

  // configuration, addresses and denial record
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cfg_q         <= '0;
      denied_addr_q <= '0;
      denied_op_q   <= op_put_full;
      release_q     <= 1'b0;
      for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
        addr_q[i] <= '0;
      end
    end else begin
      // single cycle pulse per release write
      release_q <= wr_en && (word_idx == `PMP_CSR_RELEASE);
      if (wr_en && (word_idx == `PMP_CSR_CFG)) begin
        cfg_q <= cpu_a_data_i;
      end
      if (wr_en && is_addr_reg) begin
        addr_q[addr_sel] <= cpu_a_data_i;
      end
      if (deny_i) begin
        denied_addr_q <= deny_addr_i;
        denied_op_q   <= deny_op_i;
      end
    end
  end

  // response valid, held until the cpu takes it
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cpu_d_valid_o <= 1'b0;
    end else if (accept) begin
      cpu_d_valid_o <= 1'b1;
    end else if (cpu_d_ready_i) begin
      cpu_d_valid_o <= 1'b0;
    end
  end

  // response payload captured with the request
  always_ff @(posedge clk) begin
    if (accept) begin
      cpu_d_opcode_o <= is_get ? access_ack_data : access_ack;
      cpu_d_data_o   <= (is_get && !req_err) ? rd_data : '0;
      cpu_d_error_o  <= req_err;
    end
  end

  assign release_o = release_q;

  // fan out config bytes, region 0 has a zero lower bound
  for (genvar g = 0; g < `PMP_NUM_REGIONS; g++) begin : g_region_out
    assign region_cfg_o[g]  = cfg_q[g*`PMP_CFG_BITS +: `PMP_CFG_BITS];
    assign region_addr_o[g] = addr_q[g];
    if (g == 0) begin : g_base_zero
      assign region_base_o[g] = '0;
    end else begin : g_base_prev
      assign region_base_o[g] = addr_q[g-1];
    end
  end

  // a raised response keeps valid and payload until accepted
  a_cpu_rsp_hold: assert property (
    @(posedge clk) disable iff (!rst)
    cpu_d_valid_o && !cpu_d_ready_i |=> cpu_d_valid_o && $stable(cpu_d_data_o)
  );

endmodule

//--- source/pmp_guard_consts.svh
// Access guard constants
`ifndef PMP_GUARD_CONSTS_SVH
`define PMP_GUARD_CONSTS_SVH

// number of protection regions, all configs share one word
`define PMP_NUM_REGIONS 4

// register map, word index taken from address bits 4:2
`define PMP_CSR_CFG         3'd0
`define PMP_CSR_ADDR0       3'd1
// indices 1 to 4 hold region addresses 0 to 3
`define PMP_CSR_DENIED_ADDR 3'd5
`define PMP_CSR_DENIED_OP   3'd6
`define PMP_CSR_RELEASE     3'd7

// per region config byte, region n sits in byte n
`define PMP_CFG_BITS     8
// read and write permission bits
`define PMP_CFG_R        0
`define PMP_CFG_W        1
// two bit matching mode
`define PMP_CFG_MODE_LSB 3

`endif

//--- source/pmp_guard_pkg.sv
// Access guard types
package pmp_guard_pkg;

  // request opcodes on the a channel
  typedef enum logic [2:0] {
    op_put_full = 3'd0,
    op_get      = 3'd4
  } bus_op_e;

  // response opcodes on the d channel
  typedef enum logic [2:0] {
    access_ack      = 3'd0,
    access_ack_data = 3'd1
  } rsp_op_e;

  // region address matching mode
  // encoding 3 is reserved and behaves as off
  typedef enum logic [1:0] {
    mode_off = 2'd0,
    mode_tor = 2'd1,
    mode_na4 = 2'd2
  } pmp_mode_e;

  // gate state, block holds until the cpu releases it
  typedef enum logic {
    st_pass  = 1'b0,
    st_block = 1'b1
  } guard_state_e;

endpackage

//--- source/pmp_guard_top.sv
// Access guard top level
`timescale 1ns/1ps
`include "pmp_guard_consts.svh"

module pmp_guard_top import pmp_guard_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // host request and response
  input  logic        h_a_valid_i,
  output logic        h_a_ready_o,
  input  bus_op_e     h_a_opcode_i,
  input  logic [31:0] h_a_address_i,
  input  logic [31:0] h_a_data_i,
  output logic        h_d_valid_o,
  input  logic        h_d_ready_i,
  output rsp_op_e     h_d_opcode_o,
  output logic [31:0] h_d_data_o,
  output logic        h_d_error_o,
  // device request and response
  output logic        dev_a_valid_o,
  input  logic        dev_a_ready_i,
  output bus_op_e     dev_a_opcode_o,
  output logic [31:0] dev_a_address_o,
  output logic [31:0] dev_a_data_o,
  input  logic        dev_d_valid_i,
  output logic        dev_d_ready_o,
  input  rsp_op_e     dev_d_opcode_i,
  input  logic [31:0] dev_d_data_i,
  input  logic        dev_d_error_i,
  // cpu register port
  input  logic        cpu_a_valid_i,
  output logic        cpu_a_ready_o,
  input  bus_op_e     cpu_a_opcode_i,
  input  logic [31:0] cpu_a_address_i,
  input  logic [31:0] cpu_a_data_i,
  output logic        cpu_d_valid_o,
  input  logic        cpu_d_ready_i,
  output rsp_op_e     cpu_d_opcode_o,
  output logic [31:0] cpu_d_data_o,
  output logic        cpu_d_error_o,
  output logic        irq_o
);

  logic [`PMP_CFG_BITS-1:0]    region_cfg  [`PMP_NUM_REGIONS];
  logic [31:0]                 region_addr [`PMP_NUM_REGIONS];
  logic [31:0]                 region_base [`PMP_NUM_REGIONS];
  logic [`PMP_NUM_REGIONS-1:0] region_match;
  logic [`PMP_NUM_REGIONS-1:0] region_allow;
  logic                        req_write;
  logic                        deny;
  logic [31:0]                 deny_addr;
  bus_op_e                     deny_op;
  logic                        release_pulse;

  // get has bit 2 set, puts do not
  assign req_write = ~h_a_opcode_i[2];

  pmp_csr_bank u_bank (
    .clk, .rst,
    .cpu_a_valid_i, .cpu_a_ready_o, .cpu_a_opcode_i, .cpu_a_address_i, .cpu_a_data_i,
    .cpu_d_valid_o, .cpu_d_ready_i, .cpu_d_opcode_o, .cpu_d_data_o, .cpu_d_error_o,
    .deny_i        (deny),
    .deny_addr_i   (deny_addr),
    .deny_op_i     (deny_op),
    .region_cfg_o  (region_cfg),
    .region_addr_o (region_addr),
    .region_base_o (region_base),
    .release_o     (release_pulse)
  );

  // one checker per region, all looking at the same host address
  for (genvar g = 0; g < `PMP_NUM_REGIONS; g++) begin : g_region
    pmp_region_check u_check (
      .cfg_i       (region_cfg[g]),
      .addr_i      (region_addr[g]),
      .base_i      (region_base[g]),
      .req_addr_i  (h_a_address_i),
      .req_write_i (req_write),
      .match_o     (region_match[g]),
      .allow_o     (region_allow[g])
    );
  end

  pmp_access_gate u_gate (
    .clk, .rst,
    .h_a_valid_i, .h_a_ready_o, .h_a_opcode_i, .h_a_address_i, .h_a_data_i,
    .h_d_valid_o, .h_d_ready_i, .h_d_opcode_o, .h_d_data_o, .h_d_error_o,
    .dev_a_valid_o, .dev_a_ready_i, .dev_a_opcode_o, .dev_a_address_o, .dev_a_data_o,
    .dev_d_valid_i, .dev_d_ready_o, .dev_d_opcode_i, .dev_d_data_i, .dev_d_error_i,
    .match_i     (region_match),
    .allow_i     (region_allow),
    .release_i   (release_pulse),
    .deny_o      (deny),
    .deny_addr_o (deny_addr),
    .deny_op_o   (deny_op),
    .irq_o
  );

endmodule

//--- source/pmp_region_check.sv
// Single region checker
`timescale 1ns/1ps
`include "pmp_guard_consts.svh"

module pmp_region_check import pmp_guard_pkg::*; (
  // config byte of this region
  input  logic [`PMP_CFG_BITS-1:0] cfg_i,
  // region top, in words
  input  logic [31:0]              addr_i,
  // lower bound for tor, in words
  input  logic [31:0]              base_i,
  // host byte address
  input  logic [31:0]              req_addr_i,
  input  logic                     req_write_i,
  output logic                     match_o,
  output logic                     allow_o
);

  pmp_mode_e   mode;
  logic [31:0] word_addr;

  assign mode = pmp_mode_e'(cfg_i[`PMP_CFG_MODE_LSB +: 2]);

  // compare in words, the low two bits select a byte
  assign word_addr = {2'b00, req_addr_i[31:2]};

  always_comb begin
    case (mode)
      // base <= addr < top
      mode_tor: match_o = (base_i <= word_addr) && (word_addr < addr_i);
      // exactly one aligned word
      mode_na4: match_o = (word_addr == addr_i);
      // off and the reserved encoding never match
      default:  match_o = 1'b0;
    endcase
  end

  // write bit for a put, read bit for a get
  assign allow_o = req_write_i ? cfg_i[`PMP_CFG_W] : cfg_i[`PMP_CFG_R];

endmodule

//--- tb/pmp_guard_checker.sv
// Access guard response checker
`timescale 1ns/1ps

module pmp_guard_checker import pmp_guard_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        h_a_valid_i,
  input logic        h_a_ready_i,
  input bus_op_e     h_a_opcode_i,
  input logic [31:0] h_a_address_i,
  input logic [31:0] h_a_data_i,
  input logic        h_d_valid_i,
  input logic        h_d_ready_i,
  input rsp_op_e     h_d_opcode_i,
  input logic [31:0] h_d_data_i,
  input logic        h_d_error_i,
  input logic        cpu_a_valid_i,
  input logic        cpu_a_ready_i,
  input bus_op_e     cpu_a_opcode_i,
  input logic [31:0] cpu_a_address_i,
  input logic [31:0] cpu_a_data_i,
  input logic        cpu_d_valid_i,
  input logic        cpu_d_ready_i,
  input rsp_op_e     cpu_d_opcode_i,
  input logic [31:0] cpu_d_data_i,
  input logic        cpu_d_error_i,
  input logic        irq_i
);

  // mirrored registers and memory
  logic [31:0] cfg_m;
  logic [31:0] addr_m [4];
  logic [31:0] den_addr_m;
  logic [31:0] den_op_m;
  logic [31:0] mem_m [logic [31:0]];
  // expected responses, {error, opcode, data}
  logic [35:0] host_exp [$];
  logic [35:0] cpu_exp [$];
  int          err_count;

  // lowest matching region decides, no match denies
  function automatic logic region_allows(input logic [31:0] addr, input logic write);
    logic [31:0] w;
    logic [31:0] lo;
    logic [1:0]  m;
    logic        hit;
    w = addr >> 2;
    for (int n = 0; n < 4; n++) begin
      m   = cfg_m[n*8+3 +: 2];
      lo  = (n == 0) ? 32'd0 : addr_m[n-1];
      hit = (m == 2'd1) ? (lo <= w && w < addr_m[n]) : (m == 2'd2) ? (w == addr_m[n]) : 1'b0;
      if (hit) begin
        return write ? cfg_m[n*8+1] : cfg_m[n*8];
      end
    end
    return 1'b0;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  always @(posedge clk or negedge rst) begin
    logic [35:0] e;
    logic        h_acc;
    logic        h_ok;
    logic        h_wr;
    logic [31:0] h_word;
    logic [2:0]  idx;
    logic        c_put;
    logic        c_get;
    logic        c_err;
    logic [31:0] c_data;
    if (!rst) begin
      cfg_m      = '0;
      den_addr_m = '0;
      den_op_m   = '0;
      for (int i = 0; i < 4; i++) begin
        addr_m[i] = '0;
      end
      host_exp.delete();
      cpu_exp.delete();
    end else begin
      // responses first, a new request cannot overlap its own answer
      if (h_d_valid_i && h_d_ready_i) begin
        if (host_exp.size() == 0) begin
          $display("host response arrived with no request outstanding");
          err_count++;
        end else begin
          e = host_exp.pop_front();
          compare("h_d_error_o", {31'd0, h_d_error_i}, {31'd0, e[35]});
          compare("h_d_opcode_o", {29'd0, h_d_opcode_i}, {29'd0, e[34:32]});
          compare("h_d_data_o", h_d_data_i, e[31:0]);
          if (e[35]) begin
            compare("irq_o", {31'd0, irq_i}, 32'd1);
          end
        end
      end
      if (cpu_d_valid_i && cpu_d_ready_i) begin
        if (cpu_exp.size() == 0) begin
          $display("cpu response arrived with no request outstanding");
          err_count++;
        end else begin
          e = cpu_exp.pop_front();
          compare("cpu_d_error_o", {31'd0, cpu_d_error_i}, {31'd0, e[35]});
          compare("cpu_d_opcode_o", {29'd0, cpu_d_opcode_i}, {29'd0, e[34:32]});
          compare("cpu_d_data_o", cpu_d_data_i, e[31:0]);
        end
      end
      // blocked guard takes no request
      if (irq_i && h_a_ready_i) begin
        compare("h_a_ready_o", 32'd1, 32'd0);
      end
      // host request judged against the config before this edge
      h_acc  = h_a_valid_i && h_a_ready_i;
      h_wr   = (h_a_opcode_i == op_put_full);
      h_word = h_a_address_i >> 2;
      h_ok   = region_allows(h_a_address_i, h_wr);
      if (h_acc) begin
        e[35]    = !h_ok;
        e[34:32] = h_wr ? 3'd0 : 3'd1;
        e[31:0]  = (!h_ok || h_wr) ? 32'd0 : (mem_m.exists(h_word) ? mem_m[h_word] : 32'd0);
        host_exp.push_back(e);
      end
      // cpu request, reads see the old record
      if (cpu_a_valid_i && cpu_a_ready_i) begin
        idx    = cpu_a_address_i[4:2];
        c_put  = (cpu_a_opcode_i == op_put_full);
        c_get  = (cpu_a_opcode_i == op_get);
        c_err  = (cpu_a_address_i[31:5] != 0) || (cpu_a_address_i[1:0] != 0) ||
                 !(c_put || c_get) || (c_put && (idx == 3'd5 || idx == 3'd6));
        c_data = '0;
        if (c_get && !c_err) begin
          case (idx)
            3'd0:    c_data = cfg_m;
            3'd5:    c_data = den_addr_m;
            3'd6:    c_data = den_op_m;
            3'd7:    c_data = '0;
            default: c_data = addr_m[idx-3'd1];
          endcase
        end
        cpu_exp.push_back({c_err, (c_get ? 3'd1 : 3'd0), c_data});
        if (c_put && !c_err && idx == 3'd0) begin
          cfg_m = cpu_a_data_i;
        end
        if (c_put && !c_err && idx >= 3'd1 && idx <= 3'd4) begin
          addr_m[idx-3'd1] = cpu_a_data_i;
        end
      end
      // host side effects land on this edge
      if (h_acc && h_ok && h_wr) begin
        mem_m[h_word] = h_a_data_i;
      end
      if (h_acc && !h_ok) begin
        den_addr_m = h_a_address_i;
        den_op_m   = {29'd0, h_a_opcode_i};
      end
    end
  end

endmodule

//--- tb/tb_pmp_guard.sv
// Access guard testbench
`timescale 1ns/1ps
`include "pmp_guard_consts.svh"

module tb_pmp_guard import pmp_guard_pkg::*; ();

  logic        clk;
  logic        rst;
  logic        h_a_valid_i, h_a_ready_o, h_d_valid_o, h_d_ready_i, h_d_error_o;
  bus_op_e     h_a_opcode_i;
  logic [31:0] h_a_address_i, h_a_data_i, h_d_data_o;
  rsp_op_e     h_d_opcode_o;
  logic        dev_a_valid_o, dev_a_ready_i, dev_d_valid_i, dev_d_ready_o, dev_d_error_i;
  bus_op_e     dev_a_opcode_o;
  logic [31:0] dev_a_address_o, dev_a_data_o, dev_d_data_i;
  rsp_op_e     dev_d_opcode_i;
  logic        cpu_a_valid_i, cpu_a_ready_o, cpu_d_valid_o, cpu_d_ready_i, cpu_d_error_o;
  bus_op_e     cpu_a_opcode_i;
  logic [31:0] cpu_a_address_i, cpu_a_data_i, cpu_d_data_o;
  rsp_op_e     cpu_d_opcode_o;
  logic        irq_o;
  integer      seed;
  int          timeouts;
  logic [31:0] dev_mem [logic [31:0]];
  logic [31:0] r;
  logic [31:0] cfg_w;

  pmp_guard_top DUT (.*);

  pmp_guard_checker u_checker (
    .clk, .rst, .h_a_valid_i, .h_a_ready_i(h_a_ready_o), .h_a_opcode_i, .h_a_address_i,
    .h_a_data_i, .h_d_valid_i(h_d_valid_o), .h_d_ready_i, .h_d_opcode_i(h_d_opcode_o),
    .h_d_data_i(h_d_data_o), .h_d_error_i(h_d_error_o), .cpu_a_valid_i,
    .cpu_a_ready_i(cpu_a_ready_o), .cpu_a_opcode_i, .cpu_a_address_i, .cpu_a_data_i,
    .cpu_d_valid_i(cpu_d_valid_o), .cpu_d_ready_i, .cpu_d_opcode_i(cpu_d_opcode_o),
    .cpu_d_data_i(cpu_d_data_o), .cpu_d_error_i(cpu_d_error_o), .irq_i(irq_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // device memory, answers one cycle after accepting
  always @(posedge clk) begin
    logic        a_acc;
    logic        d_acc;
    bus_op_e     op;
    logic [31:0] word;
    logic [31:0] wdata;
    logic [31:0] bp;
    a_acc = dev_a_valid_o && dev_a_ready_i;
    d_acc = dev_d_valid_i && dev_d_ready_o;
    op    = dev_a_opcode_o;
    word  = dev_a_address_o >> 2;
    wdata = dev_a_data_o;
    bp    = $random(seed);
    #1;
    if (d_acc) begin
      dev_d_valid_i = 1'b0;
    end
    if (a_acc) begin
      dev_d_valid_i = 1'b1;
      dev_d_error_i = 1'b0;
      dev_d_opcode_i = (op == op_get) ? access_ack_data : access_ack;
      dev_d_data_i  = (op == op_get && dev_mem.exists(word)) ? dev_mem[word] : 32'd0;
      if (op != op_get) begin
        dev_mem[word] = wdata;
      end
    end
    // random back-pressure, about one cycle in four
    dev_a_ready_i = !dev_d_valid_i && (bp[1:0] != 2'b00);
  end

  function automatic logic [31:0] csr_addr(input logic [2:0] idx);
    return {27'd0, idx, 2'b00};
  endfunction

  // bits 4:3 mode, bit 1 write, bit 0 read
  function automatic logic [7:0] cfg_byte(input logic [1:0] mode, input logic w, input logic rd);
    return {3'b000, mode, 1'b0, w, rd};
  endfunction

  task automatic host_access(input bus_op_e op, input logic [31:0] addr, input logic [31:0] data);
    int n;
    h_a_valid_i   = 1'b1;
    h_a_opcode_i  = op;
    h_a_address_i = addr;
    h_a_data_i    = data;
    n = 0;
    @(negedge clk);
    while (!h_a_ready_o && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!h_a_ready_o) begin
      $display("timeout: host request at %h never accepted", addr);
      timeouts++;
    end
    @(posedge clk);
    #1 h_a_valid_i = 1'b0;
    n = 0;
    @(negedge clk);
    while (!h_d_valid_o && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!h_d_valid_o) begin
      $display("timeout: no host response for %h", addr);
      timeouts++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic cpu_access(input bus_op_e op, input logic [31:0] addr, input logic [31:0] data);
    int n;
    cpu_a_valid_i   = 1'b1;
    cpu_a_opcode_i  = op;
    cpu_a_address_i = addr;
    cpu_a_data_i    = data;
    n = 0;
    @(negedge clk);
    while (!cpu_a_ready_o && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_a_ready_o) begin
      $display("timeout: cpu request never accepted");
      timeouts++;
    end
    @(posedge clk);
    #1 cpu_a_valid_i = 1'b0;
    n = 0;
    @(negedge clk);
    while (!cpu_d_valid_o && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_d_valid_o) begin
      $display("timeout: no cpu response");
      timeouts++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic cpu_write(input logic [2:0] idx, input logic [31:0] data);
    cpu_access(op_put_full, csr_addr(idx), data);
  endtask

  task automatic cpu_read(input logic [2:0] idx);
    cpu_access(op_get, csr_addr(idx), 32'd0);
  endtask

  // write the release register and wait for irq to fall
  task automatic release_guard();
    int n;
    cpu_write(`PMP_CSR_RELEASE, 32'd0);
    n = 0;
    @(negedge clk);
    while (irq_o && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (irq_o) begin
      $display("timeout: irq stayed high after release");
      timeouts++;
    end
    @(posedge clk);
    #1;
  endtask

  // read back the denial record, then release
  task automatic check_denial();
    if (!irq_o) begin
      $display("irq not raised after a denied request");
      timeouts++;
    end
    cpu_read(`PMP_CSR_DENIED_ADDR);
    cpu_read(`PMP_CSR_DENIED_OP);
    release_guard();
  endtask

  task automatic end_run();
    $display("checker errors %0d, other failures %0d", u_checker.err_count, timeouts);
    if (u_checker.err_count == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    seed = 32'h549f_49be;
    timeouts = 0;
    rst = 1'b0;
    h_a_valid_i = 1'b0;
    h_a_opcode_i = op_put_full;
    h_a_address_i = '0;
    h_a_data_i = '0;
    h_d_ready_i = 1'b1;
    dev_a_ready_i = 1'b0;
    dev_d_valid_i = 1'b0;
    dev_d_opcode_i = access_ack;
    dev_d_data_i = '0;
    dev_d_error_i = 1'b0;
    cpu_a_valid_i = 1'b0;
    cpu_a_opcode_i = op_put_full;
    cpu_a_address_i = '0;
    cpu_a_data_i = '0;
    cpu_d_ready_i = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst = 1'b1;

    // register read back and error cases
    cpu_write(`PMP_CSR_CFG, 32'h1a2b_3c4d);
    cpu_read(`PMP_CSR_CFG);
    for (int k = 0; k < 4; k++) begin
      cpu_write(`PMP_CSR_ADDR0 + 3'(k), 32'hc0de_0000 + 32'(k));
      cpu_read(`PMP_CSR_ADDR0 + 3'(k));
    end
    cpu_access(op_get, 32'h0000_0020, 32'd0);
    cpu_access(op_get, 32'h0000_0002, 32'd0);
    cpu_write(`PMP_CSR_DENIED_ADDR, 32'hffff_ffff);
    cpu_access(bus_op_e'(3'd2), csr_addr(`PMP_CSR_CFG), 32'd0);
    cpu_read(`PMP_CSR_RELEASE);

    // region 0 tor over words 0 to ff read and write, region 1 na4 read only,
    // region 2 off at word 300
    cpu_write(`PMP_CSR_ADDR0, 32'h0000_0100);
    cpu_write(`PMP_CSR_ADDR0 + 3'd1, 32'h0000_0200);
    cpu_write(`PMP_CSR_ADDR0 + 3'd2, 32'h0000_0300);
    cpu_write(`PMP_CSR_ADDR0 + 3'd3, 32'h0000_0000);
    cfg_w = {8'h00, cfg_byte(2'd0, 1'b1, 1'b1), cfg_byte(2'd2, 1'b0, 1'b1),
             cfg_byte(2'd1, 1'b1, 1'b1)};
    cpu_write(`PMP_CSR_CFG, cfg_w);
    for (int k = 0; k < 6; k++) begin
      host_access(op_put_full, 32'h40 + 32'(k) * 4, 32'h5500_0000 + 32'(k) * 32'h111);
    end
    for (int k = 0; k < 6; k++) begin
      host_access(op_get, 32'h40 + 32'(k) * 4, 32'd0);
    end

    // denials
    host_access(op_put_full, 32'h0000_0800, 32'hdead_beef);
    check_denial();
    host_access(op_get, 32'h0000_0800, 32'd0);
    host_access(op_get, 32'h0000_0c00, 32'd0);
    check_denial();
    host_access(op_get, 32'h0000_4000, 32'd0);
    check_denial();

    // request held off while blocked, completes after release
    host_access(op_put_full, 32'h0000_4004, 32'h1111_2222);
    fork
      host_access(op_get, 32'h0000_0044, 32'd0);
      begin
        repeat (4) @(posedge clk);
        #1 release_guard();
      end
    join

    // random overlapping regions and accesses
    for (int it = 0; it < 64; it++) begin
      if (it % 8 == 0) begin
        for (int k = 0; k < 4; k++) begin
          r = $random(seed);
          cfg_w[k*8 +: 8] = cfg_byte(r[1:0], r[2], r[3]);
          cpu_write(`PMP_CSR_ADDR0 + 3'(k), {27'd0, r[8:4]});
        end
        cpu_write(`PMP_CSR_CFG, cfg_w);
      end
      r = $random(seed);
      host_access(r[8] ? op_get : op_put_full, {24'd0, r[5:0], 2'b00}, $random(seed));
      if (irq_o) begin
        check_denial();
      end
    end

    repeat (4) @(posedge clk);
    end_run();
  end

endmodule
